// File: include/pid_consts.svh
`ifndef PID_CONSTS_SVH
`define PID_CONSTS_SVH

// datapath word and fixed-point format
`define PID_DATA_W 32
`define PID_Q_BITS 10   // fraction bits of every gain

// bus word address width
`define PID_ADR_W 3

// register map, word addresses
`define PID_REG_KP      0
`define PID_REG_KI      1
`define PID_REG_KD1     2
`define PID_REG_KD2     3
`define PID_REG_OUT_MAX 4
`define PID_REG_OUT_MIN 5

// output limits after reset
`define PID_RST_OUT_MAX 100
`define PID_RST_OUT_MIN (-100)

`endif

// File: source/pid_pkg.sv
`default_nettype none

`include "pid_consts.svh"

package pid_pkg;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`PID_ADR_W-1:0]  adr;
        logic [`PID_DATA_W-1:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                   ack;
        logic [`PID_DATA_W-1:0] dat;
    } wb_rsp_t;

    // gains are Q(W-Q).Q, limits are plain integers
    typedef struct packed {
        logic signed [`PID_DATA_W-1:0] kp;
        logic signed [`PID_DATA_W-1:0] ki;
        logic signed [`PID_DATA_W-1:0] kd1;
        logic signed [`PID_DATA_W-1:0] kd2;
        logic signed [`PID_DATA_W-1:0] out_max;
        logic signed [`PID_DATA_W-1:0] out_min;
    } pid_gains_t;

    typedef struct packed {
        logic                          valid;
        logic signed [`PID_DATA_W-1:0] target;
        logic signed [`PID_DATA_W-1:0] measurement;
    } pid_sample_t;

    typedef struct packed {
        logic                          valid;
        logic signed [`PID_DATA_W-1:0] out;
    } pid_result_t;

endpackage

`default_nettype wire

// File: source/pid_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "pid_consts.svh"

module pid_wb_regs (
    input  logic                i_clock,
    input  logic                i_reset,
    input  pid_pkg::wb_req_t    i_wb,
    output pid_pkg::wb_rsp_t    o_wb,
    output pid_pkg::pid_gains_t o_gains
);
    import pid_pkg::*;

    pid_gains_t             gains;
    logic                   ack;
    logic                   done;      // request seen on the previous edge
    logic                   req_new;   // first cycle of a request
    logic [`PID_DATA_W-1:0] rd_mux;
    logic [`PID_DATA_W-1:0] rd_dat;

    // a held stb keeps done high, so only the first cycle is acked
    assign req_new = i_wb.cyc && i_wb.stb && !done;

    always_comb begin
        case (int'(i_wb.adr))
            `PID_REG_KP:      rd_mux = gains.kp;
            `PID_REG_KI:      rd_mux = gains.ki;
            `PID_REG_KD1:     rd_mux = gains.kd1;
            `PID_REG_KD2:     rd_mux = gains.kd2;
            `PID_REG_OUT_MAX: rd_mux = gains.out_max;
            `PID_REG_OUT_MIN: rd_mux = gains.out_min;
            default:          rd_mux = '0;   // unmapped words read zero
        endcase
    end

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            ack           <= 1'b0;
            done          <= 1'b0;
            gains.kp      <= '0;
            gains.ki      <= '0;
            gains.kd1     <= '0;
            gains.kd2     <= '0;
            gains.out_max <= `PID_RST_OUT_MAX;
            gains.out_min <= `PID_RST_OUT_MIN;
        end else begin
            ack  <= req_new;
            done <= i_wb.cyc && i_wb.stb;

            // write lands on the same edge that raises ack
            if (req_new && i_wb.we) begin
                case (int'(i_wb.adr))
                    `PID_REG_KP:      gains.kp      <= i_wb.dat;
                    `PID_REG_KI:      gains.ki      <= i_wb.dat;
                    `PID_REG_KD1:     gains.kd1     <= i_wb.dat;
                    `PID_REG_KD2:     gains.kd2     <= i_wb.dat;
                    `PID_REG_OUT_MAX: gains.out_max <= i_wb.dat;
                    `PID_REG_OUT_MIN: gains.out_min <= i_wb.dat;
                    default: ;
                endcase
            end
        end
    end

    // read data sampled with the pre-write value
    always_ff @(posedge i_clock) begin
        if (req_new) begin
            rd_dat <= rd_mux;
        end
    end

    assign o_wb    = '{ack: ack, dat: rd_dat};
    assign o_gains = gains;

endmodule

`default_nettype wire

// File: source/pid_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "pid_consts.svh"

module pid_core (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  pid_pkg::pid_gains_t  i_gains,
    input  pid_pkg::pid_sample_t i_sample,
    output pid_pkg::pid_result_t o_result
);
    import pid_pkg::*;

    localparam int W = `PID_DATA_W;
    localparam int Q = `PID_Q_BITS;

    // full-width product, back to Q format, truncated to one word
    function automatic logic signed [W-1:0] scale(
        input logic signed [W-1:0] gain,
        input logic signed [W-1:0] x
    );
        logic signed [2*W-1:0] prod;
        prod = gain * x;
        prod = prod >>> Q;
        return prod[W-1:0];
    endfunction

    // stage 1
    logic signed [W-1:0] err_now;
    logic signed [W-1:0] prev_err;
    logic signed [W-1:0] s1_err;
    logic signed [W-1:0] s1_sum;    // e[n] + e[n-1], trapezoid
    logic signed [W-1:0] s1_diff;   // e[n] - e[n-1]
    logic                s1_valid;

    // stage 2
    logic signed [W-1:0] integ;     // stored integrator
    logic signed [W-1:0] prev_d;    // stored derivative term
    logic signed [W-1:0] p_term;
    logic signed [W-1:0] i_cand;
    logic signed [W-1:0] d_term;
    logic signed [W-1:0] hi_room;
    logic signed [W-1:0] lo_room;
    logic signed [W-1:0] i_hi;
    logic signed [W-1:0] i_lo;
    logic signed [W-1:0] i_next;
    logic signed [W-1:0] sum_all;
    logic signed [W-1:0] out_next;
    logic signed [W-1:0] res_out;
    logic                res_valid;

    assign err_now = i_sample.target - i_sample.measurement;

    always_comb begin
        p_term = scale(i_gains.kp, s1_err);
        i_cand = integ + scale(i_gains.ki, s1_sum);

        // kd2 on the previous D gives a first-order low-pass on the derivative
        d_term = scale(i_gains.kd1, s1_diff) + scale(i_gains.kd2, prev_d);

        // anti-windup: integrator may only fill the room P leaves to each limit
        hi_room = i_gains.out_max - p_term;
        lo_room = i_gains.out_min - p_term;
        i_hi    = (hi_room > 0) ? hi_room : '0;
        i_lo    = (lo_room < 0) ? lo_room : '0;

        if (i_cand > i_hi)
            i_next = i_hi;
        else if (i_cand < i_lo)
            i_next = i_lo;
        else
            i_next = i_cand;

        sum_all = p_term + i_next + d_term;

        if (sum_all > i_gains.out_max)
            out_next = i_gains.out_max;
        else if (sum_all < i_gains.out_min)
            out_next = i_gains.out_min;
        else
            out_next = sum_all;
    end

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
            prev_err  <= '0;
            integ     <= '0;
            prev_d    <= '0;
        end else begin
            s1_valid  <= i_sample.valid;
            res_valid <= s1_valid;
            if (i_sample.valid) begin
                prev_err <= err_now;
            end
            // loop state advances once per sample leaving stage 2
            if (s1_valid) begin
                integ  <= i_next;
                prev_d <= d_term;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_sample.valid) begin
            s1_err  <= err_now;
            s1_sum  <= err_now + prev_err;
            s1_diff <= err_now - prev_err;
        end
        if (s1_valid) begin
            res_out <= out_next;
        end
    end

    assign o_result = '{valid: res_valid, out: res_out};

endmodule

`default_nettype wire

// File: source/pid_controller_top.sv
`timescale 1ns/1ps
`default_nettype none

module pid_controller_top (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  pid_pkg::wb_req_t     i_wb,
    output pid_pkg::wb_rsp_t     o_wb,
    input  pid_pkg::pid_sample_t i_sample,
    output pid_pkg::pid_result_t o_result
);
    import pid_pkg::*;

    pid_gains_t gains;   // live register values into the datapath

    pid_wb_regs u_regs (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_wb    (i_wb),
        .o_wb    (o_wb),
        .o_gains (gains)
    );

    // two-cycle sample to result
    pid_core u_core (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_gains  (gains),
        .i_sample (i_sample),
        .o_result (o_result)
    );

endmodule

`default_nettype wire

// File: verification/pid_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "pid_consts.svh"

module pid_checker (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  pid_pkg::wb_req_t     i_wb_req,
    input  pid_pkg::wb_rsp_t     i_wb_rsp,
    input  pid_pkg::pid_sample_t i_sample,
    input  pid_pkg::pid_result_t i_result,
    input  int                   i_test,
    output int                   o_errors
);
    import pid_pkg::*;

    pid_gains_t regs;            // mirror of the register bank
    int         ref_prev_err;
    int         ref_integ;
    int         ref_prev_d;
    int         exp_out[$];
    int         exp_due[$];      // cycle the result must show up
    logic       pend_valid;
    int         pend_target;
    int         pend_meas;
    int         pend_cycle;
    int         cycle;
    int         req_age;         // edges the current request has been held
    int         test_cur = 0;
    int         test_checks = 0;
    int         test_errors = 0;
    int         total_checks = 0;
    int         total_errors = 0;
    int         tests_done = 0;

    assign o_errors = total_errors;

    function automatic string test_name(input int id);
        case (id)
            1:       return "registers";
            2:       return "proportional";
            3:       return "integrator";
            4:       return "derivative";
            5:       return "saturation";
            6:       return "random";
            default: return "unknown";
        endcase
    endfunction

    // gain times value in Q format, kept to one word
    function automatic int q_mul(input int gain, input int x);
        longint prod;
        prod = longint'(gain) * longint'(x);
        return int'(prod >>> `PID_Q_BITS);
    endfunction

    // one step of the controller, advances the model state
    function automatic int pid_ref(input pid_gains_t g, input int target, input int meas);
        int err;
        int diff;
        int p;
        int cand;
        int d;
        int hi;
        int lo;
        int total;
        err = target - meas;
        diff = err - ref_prev_err;
        p = q_mul(g.kp, err);
        cand = ref_integ + q_mul(g.ki, err + ref_prev_err);   // trapezoid
        d = q_mul(g.kd1, diff) + q_mul(g.kd2, ref_prev_d);
        ref_prev_err = err;
        hi = g.out_max - p;
        lo = g.out_min - p;
        if (hi < 0) hi = 0;
        if (lo > 0) lo = 0;
        if (cand > hi) cand = hi;
        else if (cand < lo) cand = lo;
        ref_integ = cand;
        ref_prev_d = d;
        total = p + cand + d;
        if (total > g.out_max) total = g.out_max;
        else if (total < g.out_min) total = g.out_min;
        return total;
    endfunction

    function automatic int read_mirror(input int adr);
        case (adr)
            `PID_REG_KP:      return regs.kp;
            `PID_REG_KI:      return regs.ki;
            `PID_REG_KD1:     return regs.kd1;
            `PID_REG_KD2:     return regs.kd2;
            `PID_REG_OUT_MAX: return regs.out_max;
            `PID_REG_OUT_MIN: return regs.out_min;
            default:          return 0;
        endcase
    endfunction

    task automatic write_mirror(input int adr, input int dat);
        case (adr)
            `PID_REG_KP:      regs.kp = dat;
            `PID_REG_KI:      regs.ki = dat;
            `PID_REG_KD1:     regs.kd1 = dat;
            `PID_REG_KD2:     regs.kd2 = dat;
            `PID_REG_OUT_MAX: regs.out_max = dat;
            `PID_REG_OUT_MIN: regs.out_min = dat;
            default: ;        // words 6 and 7 hold nothing
        endcase
    endtask

    task automatic compare(input string name, input int expected, input int actual);
        test_checks++;
        total_checks++;
        if (expected != actual) begin
            $display("ERROR %s: expected %h, got %h (cycle %0d)", name, expected, actual, cycle);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        test_checks++;
        total_checks++;
        if (!cond) begin
            $display("%s (cycle %0d)", what, cycle);
            test_errors++;
            total_errors++;
        end
    endtask

    always @(posedge i_clock) begin
        int expected;
        if (i_reset) begin
            regs         = '0;
            regs.out_max = `PID_RST_OUT_MAX;
            regs.out_min = `PID_RST_OUT_MIN;
            ref_prev_err = 0;
            ref_integ    = 0;
            ref_prev_d   = 0;
            pend_valid   = 1'b0;
            req_age      = 0;
            cycle        = 0;
            exp_out.delete();
            exp_due.delete();
        end else begin
            cycle++;
            if (i_test != test_cur) begin
                if (test_cur != 0) begin
                    $display("test %0d (%s): %0d checks, %0d errors",
                             test_cur, test_name(test_cur), test_checks, test_errors);
                    tests_done++;
                end
                if (i_test == 0)
                    $display("tests %0d, checks %0d, errors %0d",
                             tests_done, total_checks, total_errors);
                test_cur    = i_test;
                test_checks = 0;
                test_errors = 0;
            end

            // bus side, ack expected on the second edge of a request
            if (i_wb_req.cyc && i_wb_req.stb)
                req_age++;
            else
                req_age = 0;
            if (i_wb_rsp.ack) begin
                expect_true(req_age == 2, "ack without a new request one cycle earlier");
                if (req_age == 2 && !i_wb_req.we)
                    compare("o_wb.dat", read_mirror(int'(i_wb_req.adr)), i_wb_rsp.dat);
                else if (req_age == 2)
                    write_mirror(int'(i_wb_req.adr), i_wb_req.dat);
            end else if (req_age == 2) begin
                expect_true(1'b0, "no ack one cycle after the request");
            end

            while (exp_due.size() > 0 && exp_due[0] < cycle) begin
                expect_true(1'b0, "no result two cycles after an accepted sample");
                void'(exp_out.pop_front());
                void'(exp_due.pop_front());
            end
            if (i_result.valid) begin
                expect_true(exp_due.size() > 0, "result arrived with no sample waiting");
                if (exp_due.size() > 0) begin
                    expect_true(exp_due[0] == cycle, "result arrived before its cycle");
                    expected = exp_out.pop_front();
                    void'(exp_due.pop_front());
                    compare("o_result.out", expected, i_result.out);
                end
            end

            // gains in force once the sample has spent one cycle in stage 1
            if (pend_valid) begin
                exp_out.push_back(pid_ref(regs, pend_target, pend_meas));
                exp_due.push_back(pend_cycle + 2);
                pend_valid = 1'b0;
            end
            if (i_sample.valid) begin
                pend_valid  = 1'b1;
                pend_target = i_sample.target;
                pend_meas   = i_sample.measurement;
                pend_cycle  = cycle;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/pid_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pid_consts.svh"

module pid_tb;
    import pid_pkg::*;

    localparam int N_RAND = 200;
    // transfers and samples summed over tests 1 to 6
    localparam int N_XFER     = 25 + 6 + 2 + 7 + 7 + 6 + N_RAND;
    localparam int N_SAMPLES  = 10 + 40 + 16 + 12 + N_RAND;
    localparam int MAX_CYCLES = N_XFER * 4 + N_SAMPLES * 3 + 200;

    logic        clock;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    pid_sample_t sample;
    pid_result_t result;
    int          test_id;
    int          errors;
    int          cycles = 0;
    int          p_targets[10] = '{0, 100, -100, 300, 499, 500, 501, -700, 2000, -5};

    pid_controller_top pid_controller_top_i (
        .i_clock  (clock),
        .i_reset  (reset),
        .i_wb     (wb_req),
        .o_wb     (wb_rsp),
        .i_sample (sample),
        .o_result (result)
    );

    pid_checker checker_i (
        .i_clock  (clock),
        .i_reset  (reset),
        .i_wb_req (wb_req),
        .i_wb_rsp (wb_rsp),
        .i_sample (sample),
        .i_result (result),
        .i_test   (test_id),
        .o_errors (errors)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic int rand_signed(input int range);
        return int'($urandom_range(2 * range)) - range;
    endfunction

    function automatic int rand_value(input int adr);
        case (adr)
            `PID_REG_KP:      return rand_signed(2048);
            `PID_REG_KI:      return rand_signed(512);
            `PID_REG_KD1:     return rand_signed(2048);
            `PID_REG_KD2:     return rand_signed(900);   // below 1.0 so the filter stays stable
            `PID_REG_OUT_MAX: return int'($urandom_range(5000, 100));
            `PID_REG_OUT_MIN: return -int'($urandom_range(5000, 100));
            default:          return int'($urandom);
        endcase
    endfunction

    // classic cycle with stb kept up for hold more cycles after the ack
    task automatic transfer(input logic we, input int adr, input int dat, input int hold);
        @(posedge clock);
        #1;
        sample.valid = 1'b0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: 3'(adr), dat: dat};
        do begin
            @(posedge clock);
            #1;
        end while (!wb_rsp.ack);
        @(posedge clock);   // request stays up through the ack cycle
        repeat (hold) @(posedge clock);
        #1;
        wb_req = '0;
    endtask

    task automatic write_reg(input int adr, input int dat);
        transfer(1'b1, adr, dat, 0);
    endtask

    task automatic read_reg(input int adr);
        transfer(1'b0, adr, 0, 0);
    endtask

    task automatic send_sample(input int target, input int meas);
        @(posedge clock);
        #1;
        sample = '{valid: 1'b1, target: target, measurement: meas};
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
            sample.valid = 1'b0;
        end
    endtask

    initial begin
        int pick;
        int adr;
        void'($urandom(33333));
        wb_req  = '0;
        sample  = '0;
        test_id = 0;
        reset   = 1'b1;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        idle_cycles(2);

        test_id = 1;
        for (int a = 0; a < 8; a++) read_reg(a);
        for (int a = 0; a < 8; a++) write_reg(a, int'($urandom));
        for (int a = 0; a < 8; a++) read_reg(a);
        transfer(1'b0, `PID_REG_KP, 0, 3);   // held stb gets one ack only

        test_id = 2;
        write_reg(`PID_REG_KI, 0);
        write_reg(`PID_REG_KD1, 0);
        write_reg(`PID_REG_KD2, 0);
        write_reg(`PID_REG_KP, 2048);        // 2.0
        write_reg(`PID_REG_OUT_MAX, 1000);
        write_reg(`PID_REG_OUT_MIN, -1000);
        for (int i = 0; i < 10; i++) send_sample(p_targets[i], i * 7);
        idle_cycles(3);

        test_id = 3;
        write_reg(`PID_REG_KP, 0);
        write_reg(`PID_REG_KI, 256);         // 0.25
        for (int i = 0; i < 30; i++) send_sample(200, 0);
        for (int i = 0; i < 10; i++) send_sample(0, 200);   // sign flip
        idle_cycles(3);

        test_id = 4;
        write_reg(`PID_REG_KI, 0);
        write_reg(`PID_REG_OUT_MAX, 0);      // zero room empties the integrator
        write_reg(`PID_REG_OUT_MIN, 0);
        send_sample(0, 0);
        idle_cycles(2);
        write_reg(`PID_REG_OUT_MAX, 100000);
        write_reg(`PID_REG_OUT_MIN, -100000);
        write_reg(`PID_REG_KD1, 4096);
        write_reg(`PID_REG_KD2, 512);
        for (int i = 0; i < 3; i++) send_sample(1000, 0);
        for (int i = 0; i < 12; i++) send_sample(1000, 400);
        idle_cycles(3);

        test_id = 5;
        write_reg(`PID_REG_KD1, 0);
        write_reg(`PID_REG_KD2, 0);
        write_reg(`PID_REG_KP, 4096);
        write_reg(`PID_REG_OUT_MAX, 500);
        write_reg(`PID_REG_OUT_MIN, -300);
        for (int i = 0; i < 3; i++) send_sample(10000, 0);
        for (int i = 0; i < 3; i++) send_sample(-10000, 0);
        idle_cycles(2);
        write_reg(`PID_REG_OUT_MAX, 200);
        write_reg(`PID_REG_OUT_MIN, -50);
        for (int i = 0; i < 3; i++) send_sample(10000, 0);
        for (int i = 0; i < 3; i++) send_sample(-10000, 0);
        idle_cycles(3);

        test_id = 6;
        for (int a = 0; a < 6; a++) write_reg(a, rand_value(a));
        for (int n = 0; n < N_RAND; n++) begin
            pick = int'($urandom_range(99));
            if (pick < 70) begin
                send_sample(rand_signed(20000), rand_signed(20000));
            end else if (pick < 85) begin
                idle_cycles(1);
            end else begin
                adr = int'($urandom_range(7));
                write_reg(adr, rand_value(adr));
            end
        end
        idle_cycles(5);

        test_id = 0;
        repeat (2) @(posedge clock);
        #1;
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
source/pid_pkg.sv
source/pid_wb_regs.sv
source/pid_core.sv
source/pid_controller_top.sv
verification/pid_checker.sv
verification/pid_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the PID controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module pid_tb -o pid_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/pid_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
fi
exit 1
